/* ooo_core.f */
+incdir+verif
hw/ooo_pkg.sv
hw/rename_stage.sv
hw/issue_stage.sv
hw/execute_stage.sv
hw/phys_regfile.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
verif/ooo_core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - hw/ooo_pkg.sv
  - hw/rename_stage.sv
  - hw/issue_stage.sv
  - hw/execute_stage.sv
  - hw/phys_regfile.sv
  - hw/reorder_buffer.sv
  - hw/ooo_core.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/ooo_core_tb.sv

/* verif/ooo_model.svh */
`ifndef ooo_model_svh
`define ooo_model_svh

//////////////////////////////////////////////////
// architectural reference state
//////////////////////////////////////////////////

// program-order register values
word_t model_regs [num_arch_regs];

// expected commits, oldest first
arch_reg_t exp_idx [$];
word_t     exp_data [$];

// core comes out of reset with every register at zero
function automatic void reset_model();
  for (int r = 0; r < num_arch_regs; r++) begin
    model_regs[r] = '0;
  end
  exp_idx.delete();
  exp_data.delete();
endfunction

//////////////////////////////////////////////////
// instruction semantics
//////////////////////////////////////////////////

// all results wrap at 16 bits
function automatic word_t expected_value(op_e op, word_t a, word_t b, word_t imm);
  logic [31:0] product;
  logic [31:0] wide;
  product = {16'h0000, a} * {16'h0000, b};
  case (op)
    op_li:   wide = {16'h0000, imm};
    op_add:  wide = {16'h0000, a} + {16'h0000, b};
    // borrow falls off the top
    op_sub:  wide = {16'h0000, a} - {16'h0000, b};
    op_xor:  wide = {16'h0000, a ^ b};
    // low half of the full product only
    op_mul:  wide = product;
    default: wide = '0;
  endcase
  return wide[15:0];
endfunction

// one accepted instruction, applied in program order
function automatic void apply_instruction(op_e op, arch_reg_t dest, arch_reg_t src_a,
                                          arch_reg_t src_b, word_t imm);
  word_t value;
  value = expected_value(op, model_regs[src_a], model_regs[src_b], imm);
  model_regs[dest] = value;
  exp_idx.push_back(dest);
  exp_data.push_back(value);
endfunction

`endif

/* verif/ooo_core_tb.sv */
`timescale 1ns/10ps

module ooo_core_tb import ooo_pkg::*; ();

  // phase lengths
  localparam int li_count = num_arch_regs;
  localparam int chain_count = 40;
  localparam int mix_count = 30;
  localparam int mul_chain_count = 24;
  localparam int random_count = 220;
  // two setup loads before the multiply chains
  localparam int num_instr = li_count + chain_count + mix_count + 2 + mul_chain_count +
                             random_count;
  localparam int timeout_cycles = num_instr * 20 + 100;

  logic      clock;
  logic      reset;
  logic      dispatch_valid;
  op_e       dispatch_op;
  arch_reg_t dispatch_dest;
  arch_reg_t dispatch_src_a;
  arch_reg_t dispatch_src_b;
  word_t     dispatch_imm;
  logic      dispatch_ready;
  logic      commit_valid;
  arch_reg_t commit_idx;
  word_t     commit_data;

  integer seed = 26;
  int value_errors = 0;
  int other_errors = 0;
  int accepted_count = 0;
  int commit_count = 0;
  int cycle_count = 0;
  logic stall_seen;
  arch_reg_t last_dest;

  `include "ooo_model.svh"

  ooo_core dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      value_errors++;
    end
  endtask

  function automatic arch_reg_t pick_reg();
    logic [31:0] r;
    r = $random(seed);
    return r[2:0];
  endfunction

  function automatic word_t pick_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // add twice as likely as sub or xor
  function automatic op_e pick_alu_op();
    logic [31:0] r;
    r = $random(seed);
    case (r[1:0])
      2'd0:    return op_sub;
      2'd1:    return op_xor;
      default: return op_add;
    endcase
  endfunction

  // entered and left a step after a rising edge
  task automatic drive_instr(input op_e op, input arch_reg_t dest, input arch_reg_t src_a,
                             input arch_reg_t src_b, input word_t imm);
    // ready only moves at the edge
    while (!dispatch_ready) begin
      stall_seen = 1'b1;
      @(posedge clock);
      #1;
    end
    dispatch_valid = 1'b1;
    dispatch_op = op;
    dispatch_dest = dest;
    dispatch_src_a = src_a;
    dispatch_src_b = src_b;
    dispatch_imm = imm;
    apply_instruction(op, dest, src_a, src_b, imm);
    accepted_count++;
    last_dest = dest;
    @(posedge clock);
    #1;
    dispatch_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // commit monitor and watchdog
  //////////////////////////////////////////////////

  // outputs settle well before the falling edge
  always @(negedge clock) begin
    if (!reset && commit_valid) begin
      commit_count++;
      if (exp_idx.size() == 0) begin
        $display("Unexpected commit at %0t to register %0d with nothing left to retire",
                 $time, commit_idx);
        other_errors++;
      end else begin
        check_value("commit_idx", commit_idx, exp_idx.pop_front());
        check_value("commit_data", commit_data, exp_data.pop_front());
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, commits stalled with %0d still expected",
               cycle_count, exp_idx.size());
      $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_op = op_li;
    dispatch_dest = '0;
    dispatch_src_a = '0;
    dispatch_src_b = '0;
    dispatch_imm = '0;
    stall_seen = 1'b0;
    last_dest = '0;
    reset_model();
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;

    // idle core has nothing to retire
    repeat (4) begin
      @(negedge clock);
      check_value("commit_valid", commit_valid, 0);
      check_value("dispatch_ready", dispatch_ready, 1);
    end
    @(posedge clock);
    #1;

    // load every register
    for (int i = 0; i < li_count; i++) begin
      drive_instr(op_li, arch_reg_t'(i), pick_reg(), pick_reg(), pick_word());
    end

    // each op reads the previous result
    for (int i = 0; i < chain_count; i++) begin
      drive_instr(pick_alu_op(), pick_reg(), last_dest, pick_reg(), '0);
    end

    // products go to r0..r3 and independent alu work to r4..r7
    for (int i = 0; i < mix_count; i++) begin
      if (i % 3 == 0)
        drive_instr(op_mul, pick_reg() & 3'd3, pick_reg() & 3'd3,
                    pick_reg() & 3'd3, '0);
      else
        drive_instr(pick_alu_op(), pick_reg() | 3'd4, pick_reg() | 3'd4,
                    pick_reg() | 3'd4, '0);
    end

    // serial multiplies outrun the window
    drive_instr(op_li, 3'd1, 3'd0, 3'd0, 16'd3);
    drive_instr(op_li, 3'd2, 3'd0, 3'd0, pick_word() | 16'd1);
    stall_seen = 1'b0;
    for (int i = 0; i < mul_chain_count; i++) begin
      drive_instr(op_mul, 3'd1, 3'd1, 3'd2, '0);
    end
    if (!stall_seen) begin
      $display("dispatch_ready never dropped during the multiply chain");
      other_errors++;
    end

    // long mixed run recycles the tags
    for (int i = 0; i < random_count; i++) begin
      if (pick_word() % 4 == 0)
        drive_instr(op_mul, pick_reg(), pick_reg(), pick_reg(), '0);
      else if (pick_word() % 5 == 0)
        drive_instr(op_li, pick_reg(), pick_reg(), pick_reg(), pick_word());
      else
        drive_instr(pick_alu_op(), pick_reg(), pick_reg(), pick_reg(), '0);
    end

    // drain and then watch for stray commits
    while (exp_idx.size() != 0) begin
      @(posedge clock);
    end
    repeat (20) @(posedge clock);
    check_value("commit_count", commit_count, accepted_count);

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* hw/ooo_core.sv */
`timescale 1ns/10ps

module ooo_core import ooo_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      dispatch_valid,
  input  op_e       dispatch_op,
  input  arch_reg_t dispatch_dest,
  input  arch_reg_t dispatch_src_a,
  input  arch_reg_t dispatch_src_b,
  input  word_t     dispatch_imm,
  output logic      dispatch_ready,
  output logic      commit_valid,
  output arch_reg_t commit_idx,
  output word_t     commit_data
);

  // structural stalls
  logic rob_full;
  logic rs_full;

  // renamed op to the station and the rob
  logic      ren_valid;
  op_e       ren_op;
  phys_reg_t ren_tag;
  phys_reg_t ren_tag_a;
  phys_reg_t ren_tag_b;
  logic      ren_ready_a;
  logic      ren_ready_b;
  word_t     ren_imm;
  arch_reg_t ren_dest;
  phys_reg_t ren_tag_old;

  // issue registers
  logic      alu_issue;
  op_e       alu_op;
  phys_reg_t alu_dest;
  phys_reg_t alu_src_a;
  phys_reg_t alu_src_b;
  word_t     alu_imm;
  logic      mul_issue;
  phys_reg_t mul_dest;
  phys_reg_t mul_src_a;
  phys_reg_t mul_src_b;

  // operand values
  word_t alu_a;
  word_t alu_b;
  word_t mul_a;
  word_t mul_b;

  // two writeback ports
  logic      alu_done;
  phys_reg_t alu_tag;
  word_t     alu_result;
  logic      mul_done;
  phys_reg_t mul_tag;
  word_t     mul_result;

  // retire side
  phys_reg_t head_tag;
  word_t     head_value;
  logic      free_valid;
  phys_reg_t free_tag;

  //////////////////////////////////////////////////
  // stages, ports match by name
  //////////////////////////////////////////////////

  rename_stage rename_i (.*);

  issue_stage issue_i (.*);

  execute_stage execute_i (.*);

  phys_regfile regfile_i (.*);

  reorder_buffer rob_i (.*);

endmodule

/* hw/reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer import ooo_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      ren_valid,
  input  arch_reg_t ren_dest,
  input  phys_reg_t ren_tag,
  input  phys_reg_t ren_tag_old,
  input  logic      alu_done,
  input  phys_reg_t alu_tag,
  input  logic      mul_done,
  input  phys_reg_t mul_tag,
  input  word_t     head_value,
  output logic      rob_full,
  output phys_reg_t head_tag,
  output logic      free_valid,
  output phys_reg_t free_tag,
  output logic      commit_valid,
  output arch_reg_t commit_idx,
  output word_t     commit_data
);

  typedef logic [$clog2(rob_size)-1:0] rob_idx_t;

  // entry fields
  arch_reg_t rob_dest [rob_size];
  phys_reg_t rob_tag [rob_size];
  phys_reg_t rob_tag_old [rob_size];
  logic [rob_size-1:0] rob_done;

  // pointers with wrap bit
  rob_ptr_t head_ptr;
  rob_ptr_t tail_ptr;
  rob_idx_t head_idx;
  rob_idx_t tail_idx;
  logic rob_empty;
  logic retire;

  assign head_idx = head_ptr[$clog2(rob_size)-1:0];
  assign tail_idx = tail_ptr[$clog2(rob_size)-1:0];
  // same slot, wrap bits tell full from empty
  assign rob_empty = head_ptr == tail_ptr;
  assign rob_full = head_idx == tail_idx &&
                    head_ptr[$clog2(rob_size)] != tail_ptr[$clog2(rob_size)];

  // in-order retire, one per cycle
  assign retire = !rob_empty && rob_done[head_idx];
  assign head_tag = rob_tag[head_idx];
  assign free_valid = retire;
  assign free_tag = rob_tag_old[head_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      rob_done <= '0;
      commit_valid <= 1'b0;
    end else begin
      // done by tag match, stale slots get cleared on alloc
      for (int i = 0; i < rob_size; i++) begin
        if ((alu_done && rob_tag[i] == alu_tag) || (mul_done && rob_tag[i] == mul_tag))
          rob_done[i] <= 1'b1;
      end
      if (ren_valid) begin
        rob_done[tail_idx] <= 1'b0;
        tail_ptr <= tail_ptr + 1'b1;
      end
      if (retire)
        head_ptr <= head_ptr + 1'b1;
      commit_valid <= retire;
    end
  end

  // entry payload and registered commit data
  always_ff @(posedge clock) begin
    if (ren_valid) begin
      rob_dest[tail_idx] <= ren_dest;
      rob_tag[tail_idx] <= ren_tag;
      rob_tag_old[tail_idx] <= ren_tag_old;
    end
    commit_idx <= rob_dest[head_idx];
    commit_data <= head_value;
  end

endmodule

/* hw/phys_regfile.sv */
`timescale 1ns/10ps

module phys_regfile import ooo_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  // alu writeback
  input  logic      alu_done,
  input  phys_reg_t alu_tag,
  input  word_t     alu_result,
  // multiplier writeback
  input  logic      mul_done,
  input  phys_reg_t mul_tag,
  input  word_t     mul_result,
  // operand reads for the issued ops
  input  phys_reg_t alu_src_a,
  input  phys_reg_t alu_src_b,
  input  phys_reg_t mul_src_a,
  input  phys_reg_t mul_src_b,
  // retire read
  input  phys_reg_t head_tag,
  output word_t     alu_a,
  output word_t     alu_b,
  output word_t     mul_a,
  output word_t     mul_b,
  output word_t     head_value
);

  word_t regs [num_phys_regs];

  // two units never complete the same tag in one cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int p = 0; p < num_phys_regs; p++) begin
        regs[p] <= '0;
      end
    end else begin
      if (alu_done)
        regs[alu_tag] <= alu_result;
      if (mul_done)
        regs[mul_tag] <= mul_result;
    end
  end

  // async reads, value is in place once the tag shows ready
  assign alu_a = regs[alu_src_a];
  assign alu_b = regs[alu_src_b];
  assign mul_a = regs[mul_src_a];
  assign mul_b = regs[mul_src_b];
  assign head_value = regs[head_tag];

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage import ooo_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      alu_issue,
  input  op_e       alu_op,
  input  phys_reg_t alu_dest,
  input  word_t     alu_imm,
  input  logic      mul_issue,
  input  phys_reg_t mul_dest,
  input  word_t     alu_a,
  input  word_t     alu_b,
  input  word_t     mul_a,
  input  word_t     mul_b,
  output logic      alu_done,
  output phys_reg_t alu_tag,
  output word_t     alu_result,
  output logic      mul_done,
  output phys_reg_t mul_tag,
  output word_t     mul_result
);

  //////////////////////////////////////////////////
  // single cycle alu
  //////////////////////////////////////////////////

  word_t alu_value;

  // wraps modulo 2^16
  always_comb begin
    case (alu_op)
      op_li:   alu_value = alu_imm;
      op_add:  alu_value = alu_a + alu_b;
      op_sub:  alu_value = alu_a - alu_b;
      op_xor:  alu_value = alu_a ^ alu_b;
      default: alu_value = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // pipelined multiplier
  //////////////////////////////////////////////////

  logic [mul_latency-1:0] mul_pipe_valid;
  phys_reg_t mul_pipe_tag [mul_latency];
  word_t     mul_pipe_data [mul_latency];

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_done <= 1'b0;
      mul_pipe_valid <= '0;
    end else begin
      alu_done <= alu_issue;
      mul_pipe_valid <= {mul_pipe_valid[mul_latency-2:0], mul_issue};
    end
  end

  always_ff @(posedge clock) begin
    alu_tag <= alu_dest;
    alu_result <= alu_value;
    // 16 bit target keeps the low half of the product
    mul_pipe_tag[0] <= mul_dest;
    mul_pipe_data[0] <= mul_a * mul_b;
    for (int s = 1; s < mul_latency; s++) begin
      mul_pipe_tag[s] <= mul_pipe_tag[s-1];
      mul_pipe_data[s] <= mul_pipe_data[s-1];
    end
  end

  // last stage drives the writeback port
  assign mul_done = mul_pipe_valid[mul_latency-1];
  assign mul_tag = mul_pipe_tag[mul_latency-1];
  assign mul_result = mul_pipe_data[mul_latency-1];

endmodule

/* hw/issue_stage.sv */
`timescale 1ns/10ps

module issue_stage import ooo_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      ren_valid,
  input  op_e       ren_op,
  input  phys_reg_t ren_tag,
  input  phys_reg_t ren_tag_a,
  input  phys_reg_t ren_tag_b,
  input  logic      ren_ready_a,
  input  logic      ren_ready_b,
  input  word_t     ren_imm,
  input  logic      alu_done,
  input  phys_reg_t alu_tag,
  input  logic      mul_done,
  input  phys_reg_t mul_tag,
  output logic      rs_full,
  output logic      alu_issue,
  output op_e       alu_op,
  output phys_reg_t alu_dest,
  output phys_reg_t alu_src_a,
  output phys_reg_t alu_src_b,
  output word_t     alu_imm,
  output logic      mul_issue,
  output phys_reg_t mul_dest,
  output phys_reg_t mul_src_a,
  output phys_reg_t mul_src_b
);

  typedef logic [$clog2(rs_size)-1:0] rs_idx_t;

  // station entries
  logic [rs_size-1:0] rs_valid;
  logic [rs_size-1:0] rs_rdy_a;
  logic [rs_size-1:0] rs_rdy_b;
  op_e       rs_op [rs_size];
  phys_reg_t rs_tag [rs_size];
  phys_reg_t rs_tag_a [rs_size];
  phys_reg_t rs_tag_b [rs_size];
  word_t     rs_imm [rs_size];

  // wakeup and select
  logic [rs_size-1:0] wake_a;
  logic [rs_size-1:0] wake_b;
  logic [rs_size-1:0] alu_req;
  logic [rs_size-1:0] mul_req;
  rs_idx_t alloc_idx;
  rs_idx_t alu_idx;
  rs_idx_t mul_idx;

  // walk down so the lowest index wins
  always_comb begin
    alloc_idx = '0;
    alu_idx = '0;
    mul_idx = '0;
    for (int i = rs_size - 1; i >= 0; i--) begin
      wake_a[i] = (alu_done && alu_tag == rs_tag_a[i]) || (mul_done && mul_tag == rs_tag_a[i]);
      wake_b[i] = (alu_done && alu_tag == rs_tag_b[i]) || (mul_done && mul_tag == rs_tag_b[i]);
      alu_req[i] = rs_valid[i] && rs_rdy_a[i] && rs_rdy_b[i] && rs_op[i] != op_mul;
      mul_req[i] = rs_valid[i] && rs_rdy_a[i] && rs_rdy_b[i] && rs_op[i] == op_mul;
      if (!rs_valid[i])
        alloc_idx = rs_idx_t'(i);
      if (alu_req[i])
        alu_idx = rs_idx_t'(i);
      if (mul_req[i])
        mul_idx = rs_idx_t'(i);
    end
  end

  // conservative, no credit for entries leaving this cycle
  assign rs_full = &rs_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      rs_valid <= '0;
      rs_rdy_a <= '0;
      rs_rdy_b <= '0;
      alu_issue <= 1'b0;
      mul_issue <= 1'b0;
    end else begin
      rs_rdy_a <= rs_rdy_a | wake_a;
      rs_rdy_b <= rs_rdy_b | wake_b;
      alu_issue <= |alu_req;
      mul_issue <= |mul_req;
      if (|alu_req)
        rs_valid[alu_idx] <= 1'b0;
      if (|mul_req)
        rs_valid[mul_idx] <= 1'b0;
      // li has no real sources
      if (ren_valid) begin
        rs_valid[alloc_idx] <= 1'b1;
        rs_rdy_a[alloc_idx] <= ren_ready_a || ren_op == op_li;
        rs_rdy_b[alloc_idx] <= ren_ready_b || ren_op == op_li;
      end
    end
  end

  // entry payload and issue registers
  always_ff @(posedge clock) begin
    if (ren_valid) begin
      rs_op[alloc_idx] <= ren_op;
      rs_tag[alloc_idx] <= ren_tag;
      rs_tag_a[alloc_idx] <= ren_tag_a;
      rs_tag_b[alloc_idx] <= ren_tag_b;
      rs_imm[alloc_idx] <= ren_imm;
    end
    alu_op <= rs_op[alu_idx];
    alu_dest <= rs_tag[alu_idx];
    alu_src_a <= rs_tag_a[alu_idx];
    alu_src_b <= rs_tag_b[alu_idx];
    alu_imm <= rs_imm[alu_idx];
    mul_dest <= rs_tag[mul_idx];
    mul_src_a <= rs_tag_a[mul_idx];
    mul_src_b <= rs_tag_b[mul_idx];
  end

endmodule

/* hw/rename_stage.sv */
`timescale 1ns/10ps

module rename_stage import ooo_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      dispatch_valid,
  input  op_e       dispatch_op,
  input  arch_reg_t dispatch_dest,
  input  arch_reg_t dispatch_src_a,
  input  arch_reg_t dispatch_src_b,
  input  word_t     dispatch_imm,
  input  logic      rob_full,
  input  logic      rs_full,
  input  logic      alu_done,
  input  phys_reg_t alu_tag,
  input  logic      mul_done,
  input  phys_reg_t mul_tag,
  input  logic      free_valid,
  input  phys_reg_t free_tag,
  output logic      dispatch_ready,
  output logic      ren_valid,
  output op_e       ren_op,
  output phys_reg_t ren_tag,
  output phys_reg_t ren_tag_a,
  output phys_reg_t ren_tag_b,
  output logic      ren_ready_a,
  output logic      ren_ready_b,
  output word_t     ren_imm,
  output arch_reg_t ren_dest,
  output phys_reg_t ren_tag_old
);

  // arch reg -> current phys tag
  phys_reg_t map_table [num_arch_regs];
  // value present in the regfile, per phys tag
  logic [num_phys_regs-1:0] tag_ready;

  // circular free list, never empty while the rob has room
  phys_reg_t free_list [free_list_size];
  logic [$clog2(free_list_size)-1:0] fl_head;
  logic [$clog2(free_list_size)-1:0] fl_tail;

  // completing tags this cycle, one-hot
  logic [num_phys_regs-1:0] done_mask;

  always_comb begin
    done_mask = '0;
    if (alu_done)
      done_mask[alu_tag] = 1'b1;
    if (mul_done)
      done_mask[mul_tag] = 1'b1;
  end

  // only stall source for the front end
  assign dispatch_ready = !rob_full && !rs_full;
  assign ren_valid = dispatch_valid && dispatch_ready;

  // pass-through fields of the renamed op
  assign ren_op = dispatch_op;
  assign ren_imm = dispatch_imm;
  assign ren_dest = dispatch_dest;

  // lookups use the map before this op's own remap
  assign ren_tag = free_list[fl_head];
  assign ren_tag_a = map_table[dispatch_src_a];
  assign ren_tag_b = map_table[dispatch_src_b];
  assign ren_tag_old = map_table[dispatch_dest];

  // forward a completion landing in the same cycle
  assign ren_ready_a = tag_ready[ren_tag_a] || done_mask[ren_tag_a];
  assign ren_ready_b = tag_ready[ren_tag_b] || done_mask[ren_tag_b];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, free list holds the upper tags
      for (int r = 0; r < num_arch_regs; r++) begin
        map_table[r] <= phys_reg_t'(r);
      end
      for (int f = 0; f < free_list_size; f++) begin
        free_list[f] <= phys_reg_t'(num_arch_regs + f);
      end
      tag_ready <= '1;
      fl_head <= '0;
      fl_tail <= '0;
    end else begin
      tag_ready <= tag_ready | done_mask;
      // new tag is pending until its producer completes
      if (ren_valid) begin
        map_table[dispatch_dest] <= ren_tag;
        tag_ready[ren_tag] <= 1'b0;
        fl_head <= fl_head + 1'b1;
      end
      // old tag of a retired op comes back
      if (free_valid) begin
        free_list[fl_tail] <= free_tag;
        fl_tail <= fl_tail + 1'b1;
      end
    end
  end

endmodule

/* hw/ooo_pkg.sv */
package ooo_pkg;

  //////////////////////////////////////////////////
  // machine sizes
  //////////////////////////////////////////////////

  // data path width
  localparam int word_width = 16;
  // architectural and physical register counts
  localparam int num_arch_regs = 8;
  localparam int num_phys_regs = 16;
  // window sizes
  localparam int rob_size = 8;
  localparam int rs_size = 4;
  // multiplier depth, one new op per cycle
  localparam int mul_latency = 3;
  // tags not mapped at any time, same count as rob entries
  localparam int free_list_size = num_phys_regs - num_arch_regs;

  //////////////////////////////////////////////////
  // common types
  //////////////////////////////////////////////////

  typedef logic [word_width-1:0] word_t;
  typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;
  typedef logic [$clog2(num_phys_regs)-1:0] phys_reg_t;

  // extra msb is the wrap bit
  typedef logic [$clog2(rob_size):0] rob_ptr_t;

  // decoded opcodes, all results are modulo 2^16
  typedef enum logic [2:0] {
    op_li,
    op_add,
    op_sub,
    op_xor,
    op_mul
  } op_e;

endpackage
